//--- common/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// machine csr map
`define CSR_A_MSTATUS       12'h300
`define CSR_A_MISA          12'h301
`define CSR_A_MIE           12'h304
`define CSR_A_MTVEC         12'h305
`define CSR_A_MSCRATCH      12'h340
`define CSR_A_MEPC          12'h341
`define CSR_A_MCAUSE        12'h342
`define CSR_A_MTVAL         12'h343
`define CSR_A_MIP           12'h344
`define CSR_A_VENDOR        12'hf11
`define CSR_A_ARCH          12'hf12
`define CSR_A_IMPL          12'hf13
`define CSR_A_HART          12'hf14

// writable bits: mie(3), mpie(7), mpp(12:11)
`define CSR_MSTATUS_MASK    32'h0000_1888
// msi(3), mti(7), mei(11)
`define CSR_IRQ_MASK        12'h888

// mtvec after reset, direct mode
`define CSR_RESET_VECTOR    32'h0000_0100

// read-only id words
`define CSR_VENDOR_ID       32'h0000_0000
`define CSR_ARCH_ID         32'h0000_0000
`define CSR_IMPL_ID         32'h0000_0001
`define CSR_HART_ID         32'h0000_0000

`endif

//--- common/csr_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

    // privilege modes, encoded as in the mpp field
    typedef enum logic [1:0] {
        MODE_USER    = 2'd0,
        MODE_MACHINE = 2'd3
    } mode_e;

    // csr address, raw or split into its access fields
    typedef union packed {
        logic [`CSR_ADDR_W-1:0] raw;
        struct packed {
            logic [1:0] rw;
            logic [1:0] priv;
            logic [7:0] index;
        } f;
    } csr_addr_u;

    // --------------------------------------------------
    // interrupt causes, bit 31 marks an interrupt
    // --------------------------------------------------
    localparam logic [`CSR_XLEN-1:0] IRQ_CAUSE_MSI = 32'h8000_0003;
    localparam logic [`CSR_XLEN-1:0] IRQ_CAUSE_MTI = 32'h8000_0007;
    localparam logic [`CSR_XLEN-1:0] IRQ_CAUSE_MEI = 32'h8000_000b;

    // exception causes
    localparam logic [`CSR_XLEN-1:0] EXC_INS_MISALIGNED   = 32'd0;
    localparam logic [`CSR_XLEN-1:0] EXC_INS_FAULT        = 32'd1;
    localparam logic [`CSR_XLEN-1:0] EXC_ILLEGAL          = 32'd2;
    localparam logic [`CSR_XLEN-1:0] EXC_LOAD_MISALIGNED  = 32'd4;
    localparam logic [`CSR_XLEN-1:0] EXC_STORE_MISALIGNED = 32'd6;
    localparam logic [`CSR_XLEN-1:0] EXC_ECALL_U          = 32'd8;
    localparam logic [`CSR_XLEN-1:0] EXC_ECALL_M          = 32'd11;

endpackage

`default_nettype wire

//--- common/csr_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

// architectural state as seen by the rest of the block
interface csr_state_if;
    csr_pkg::mode_e      mode;
    logic [`CSR_XLEN-1:0] mstatus;
    logic [11:0]          mie;
    logic [11:0]          mip_sw;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;

    modport owner  (output mode, mstatus, mie, mip_sw, mtvec, mscratch, mepc, mcause, mtval);
    modport reader (input  mode, mstatus, mie, mip_sw, mtvec, mscratch, mepc, mcause, mtval);
endinterface

// trap entry / return request into the register file
interface trap_update_if;
    logic                 take;
    logic                 ret;
    logic [`CSR_XLEN-1:0] cause;
    logic [`CSR_XLEN-1:0] value;
    logic [`CSR_XLEN-1:0] pc;

    modport source (output take, ret, cause, value, pc);
    modport sink   (input  take, ret, cause, value, pc);
endinterface

`default_nettype wire

//--- hdl/irq_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module irq_unit (
    input  wire                  irq_extern_i,
    input  wire                  irq_softw_i,
    input  wire                  irq_timer_i,
    csr_state_if.reader          state_i,
    output logic [11:0]          raw_irq_o,
    output logic                 irq_pending_o,
    output logic [`CSR_XLEN-1:0] irq_cause_o
);

    logic [11:0] irqv;
    logic        global_en;

    // lines sit at their mip positions
    assign raw_irq_o = {irq_extern_i, 3'b000, irq_timer_i, 3'b000, irq_softw_i, 3'b000};

    assign irqv = (raw_irq_o | state_i.mip_sw) & state_i.mie & `CSR_IRQ_MASK;

    // user mode is always interruptible by machine-level lines
    assign global_en = (state_i.mode == csr_pkg::MODE_USER) | state_i.mstatus[3];

    assign irq_pending_o = global_en & (|irqv);

    // --------------------------------------------------
    // cause encoder, external > software > timer
    // --------------------------------------------------
    always_comb begin
        if (irqv[11]) begin
            irq_cause_o = csr_pkg::IRQ_CAUSE_MEI;
        end else if (irqv[3]) begin
            irq_cause_o = csr_pkg::IRQ_CAUSE_MSI;
        end else begin
            irq_cause_o = csr_pkg::IRQ_CAUSE_MTI;
        end
    end

endmodule

`default_nettype wire

//--- trap/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module trap_ctrl (
    input  wire                  ex_valid_i,
    input  wire                  excp_ferr_i,
    input  wire                  excp_uerr_i,
    input  wire                  excp_maif_i,
    input  wire                  excp_mala_i,
    input  wire                  excp_masa_i,
    input  wire                  excp_ilgl_i,
    input  wire                  excp_ecall_i,
    input  wire [`CSR_XLEN-1:0]  excp_pc_i,
    input  wire [`CSR_XLEN-1:0]  excp_ins_i,
    input  wire                  trap_rtn_i,
    input  wire                  irq_pending_i,
    input  wire [`CSR_XLEN-1:0]  irq_cause_i,
    csr_state_if.reader          state_i,
    output logic                 jump_to_trap_o,
    output logic [`CSR_XLEN-1:0] trap_cause_o,
    output logic [`CSR_XLEN-1:0] trap_entry_addr_o,
    output logic [`CSR_XLEN-1:0] trap_rtn_addr_o,
    trap_update_if.source        upd_o
);

    logic                 excp_any;
    logic [`CSR_XLEN-1:0] ecause;
    logic [`CSR_XLEN-1:0] evalue;
    logic [`CSR_XLEN-1:0] tvec_base;

    assign excp_any = excp_ferr_i | excp_uerr_i | excp_ilgl_i | excp_maif_i |
                      excp_mala_i | excp_masa_i | excp_ecall_i;

    // --------------------------------------------------
    // exception cause and trap value
    // --------------------------------------------------
    always_comb begin
        evalue = '0;
        if (excp_ferr_i) begin
            ecause = csr_pkg::EXC_INS_FAULT;
        end else if (excp_uerr_i | excp_ilgl_i) begin
            ecause = csr_pkg::EXC_ILLEGAL;
            evalue = excp_ins_i;
        end else if (excp_maif_i) begin
            ecause = csr_pkg::EXC_INS_MISALIGNED;
            evalue = excp_pc_i;
        end else if (excp_mala_i) begin
            ecause = csr_pkg::EXC_LOAD_MISALIGNED;
            evalue = excp_pc_i;
        end else if (excp_masa_i) begin
            ecause = csr_pkg::EXC_STORE_MISALIGNED;
            evalue = excp_pc_i;
        end else if (state_i.mode == csr_pkg::MODE_USER) begin
            ecause = csr_pkg::EXC_ECALL_U;
        end else begin
            ecause = csr_pkg::EXC_ECALL_M;
        end
    end

    // interrupts win over any exception
    assign jump_to_trap_o = ex_valid_i & (irq_pending_i | excp_any);
    assign trap_cause_o   = irq_pending_i ? irq_cause_i : ecause;

    // vectored mode offsets interrupts by 4 * cause code
    assign tvec_base = {state_i.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign trap_entry_addr_o = (irq_pending_i & state_i.mtvec[0]) ?
                               tvec_base + {irq_cause_i[`CSR_XLEN-3:0], 2'b00} : tvec_base;

    assign trap_rtn_addr_o = state_i.mepc;

    assign upd_o.take  = jump_to_trap_o;
    assign upd_o.ret   = trap_rtn_i & ~jump_to_trap_o;
    assign upd_o.cause = trap_cause_o;
    assign upd_o.value = irq_pending_i ? '0 : evalue;
    assign upd_o.pc    = excp_pc_i;

endmodule

`default_nettype wire

//--- hdl/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_access (
    input  wire                   clk_i,
    input  wire                   resetb_i,
    input  wire                   exs_en_i,
    input  wire                   access_i,
    input  wire [`CSR_ADDR_W-1:0] addr_i,
    input  wire [11:0]            raw_irq_i,
    csr_state_if.reader           state_i,
    output logic [`CSR_XLEN-1:0]  rd_data_o,
    output logic                  bad_csr_addr_o,
    output logic                  readonly_csr_o,
    output logic                  priv_too_low_o
);

    logic [`CSR_XLEN-1:0] rd_data;
    logic                 rd_bad;
    csr_pkg::csr_addr_u   addr_q;

    // --------------------------------------------------
    // read decode
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        rd_bad  = 1'b0;
        case (addr_i)
            `CSR_A_MSTATUS  : rd_data = state_i.mstatus & `CSR_MSTATUS_MASK;
            `CSR_A_MISA     : rd_data = '0;
            `CSR_A_MIE      : rd_data = {20'b0, state_i.mie & `CSR_IRQ_MASK};
            `CSR_A_MTVEC    : rd_data = state_i.mtvec;
            `CSR_A_MSCRATCH : rd_data = state_i.mscratch;
            `CSR_A_MEPC     : rd_data = state_i.mepc;
            `CSR_A_MCAUSE   : rd_data = state_i.mcause;
            `CSR_A_MTVAL    : rd_data = state_i.mtval;
            `CSR_A_MIP      : rd_data = {20'b0, (state_i.mip_sw | raw_irq_i) & `CSR_IRQ_MASK};
            `CSR_A_VENDOR   : rd_data = `CSR_VENDOR_ID;
            `CSR_A_ARCH     : rd_data = `CSR_ARCH_ID;
            `CSR_A_IMPL     : rd_data = `CSR_IMPL_ID;
            `CSR_A_HART     : rd_data = `CSR_HART_ID;
            default         : rd_bad  = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rd_data_o      <= '0;
            bad_csr_addr_o <= 1'b0;
            addr_q         <= '0;
        end else if (exs_en_i & access_i) begin
            rd_data_o      <= rd_data;
            bad_csr_addr_o <= rd_bad;
            addr_q.raw     <= addr_i;
        end
    end

    // access checks on the registered address
    assign readonly_csr_o = (addr_q.f.rw == 2'b11);
    assign priv_too_low_o = (addr_q.f.priv > state_i.mode);

endmodule

`default_nettype wire

//--- regfile/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_regfile (
    input  wire                   clk_i,
    input  wire                   resetb_i,
    input  wire                   exs_en_i,
    input  wire                   wr_i,
    input  wire [`CSR_ADDR_W-1:0] wr_addr_i,
    input  wire [`CSR_XLEN-1:0]   wr_data_i,
    trap_update_if.sink           upd_i,
    csr_state_if.owner            state_o
);

    // mstatus field positions
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    csr_pkg::mode_e       mode_q;
    logic [`CSR_XLEN-1:0] mstatus_q;
    logic [11:0]          mie_q;
    logic [11:0]          mip_sw_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [`CSR_XLEN-1:0] mtval_q;
    logic                 sw_wr;

    // software write only when no trap or mret claims the port
    assign sw_wr = wr_i & ~upd_i.take & ~upd_i.ret;

    // --------------------------------------------------
    // mode and control registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            mode_q    <= csr_pkg::MODE_MACHINE;
            mstatus_q <= '0;
            mie_q     <= '0;
            mip_sw_q  <= '0;
            mtvec_q   <= `CSR_RESET_VECTOR;
        end else if (exs_en_i) begin
            if (upd_i.take) begin
                mstatus_q[12:11]    <= mode_q;
                mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
                mstatus_q[MIE_BIT]  <= 1'b0;
                mode_q              <= csr_pkg::MODE_MACHINE;
            end else if (upd_i.ret) begin
                mode_q              <= csr_pkg::mode_e'(mstatus_q[12:11]);
                mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
                mstatus_q[MPIE_BIT] <= 1'b1;
                mstatus_q[12:11]    <= csr_pkg::MODE_USER;
            end else if (sw_wr) begin
                case (wr_addr_i)
                    `CSR_A_MSTATUS : mstatus_q <= wr_data_i & `CSR_MSTATUS_MASK;
                    `CSR_A_MIE     : mie_q     <= wr_data_i[11:0] & `CSR_IRQ_MASK;
                    `CSR_A_MIP     : mip_sw_q  <= wr_data_i[11:0] & `CSR_IRQ_MASK;
                    // mode values >= 2 are reserved
                    `CSR_A_MTVEC   : mtvec_q   <= wr_data_i & ~`CSR_XLEN'('h2);
                    default        : ;
                endcase
            end
        end
    end

    // trap bookkeeping and scratch
    always_ff @(posedge clk_i) begin
        if (exs_en_i) begin
            if (upd_i.take) begin
                mepc_q   <= {upd_i.pc[`CSR_XLEN-1:2], 2'b00};
                mcause_q <= upd_i.cause;
                mtval_q  <= upd_i.value;
            end else if (sw_wr) begin
                case (wr_addr_i)
                    `CSR_A_MSCRATCH : mscratch_q <= wr_data_i;
                    `CSR_A_MEPC     : mepc_q     <= wr_data_i;
                    `CSR_A_MCAUSE   : mcause_q   <= wr_data_i;
                    `CSR_A_MTVAL    : mtval_q    <= wr_data_i;
                    default         : ;
                endcase
            end
        end
    end

    assign state_o.mode     = mode_q;
    assign state_o.mstatus  = mstatus_q;
    assign state_o.mie      = mie_q;
    assign state_o.mip_sw   = mip_sw_q;
    assign state_o.mtvec    = mtvec_q;
    assign state_o.mscratch = mscratch_q;
    assign state_o.mepc     = mepc_q;
    assign state_o.mcause   = mcause_q;
    assign state_o.mtval    = mtval_q;

endmodule

`default_nettype wire

//--- hdl/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_top (
    input  wire                   clk_i,
    input  wire                   resetb_i,
    input  wire                   exs_en_i,
    // csr read port
    input  wire                   access_i,
    input  wire [`CSR_ADDR_W-1:0] addr_i,
    output logic                  bad_csr_addr_o,
    output logic                  readonly_csr_o,
    output logic                  priv_too_low_o,
    output logic [`CSR_XLEN-1:0]  rd_data_o,
    // csr write port
    input  wire                   wr_i,
    input  wire [`CSR_ADDR_W-1:0] wr_addr_i,
    input  wire [`CSR_XLEN-1:0]   wr_data_i,
    // exceptions and interrupts
    input  wire                   ex_valid_i,
    input  wire                   irq_extern_i,
    input  wire                   irq_softw_i,
    input  wire                   irq_timer_i,
    input  wire                   excp_ferr_i,
    input  wire                   excp_uerr_i,
    input  wire                   excp_maif_i,
    input  wire                   excp_mala_i,
    input  wire                   excp_masa_i,
    input  wire                   excp_ilgl_i,
    input  wire                   excp_ecall_i,
    input  wire [`CSR_XLEN-1:0]   excp_pc_i,
    input  wire [`CSR_XLEN-1:0]   excp_ins_i,
    input  wire                   trap_rtn_i,
    // trap control
    output logic                  interrupt_o,
    output logic                  jump_to_trap_o,
    output logic [`CSR_XLEN-1:0]  trap_entry_addr_o,
    output logic [`CSR_XLEN-1:0]  trap_rtn_addr_o,
    output logic [1:0]            mode_o,
    output logic [`CSR_XLEN-1:0]  trap_cause_o
);

    logic [11:0]          raw_irq;
    logic                 irq_pending;
    logic [`CSR_XLEN-1:0] irq_cause;

    csr_state_if   state_if ();
    trap_update_if upd_if ();

    assign mode_o      = state_if.mode;
    assign interrupt_o = irq_pending;

    irq_unit irq_unit_i (
        .irq_extern_i (irq_extern_i),
        .irq_softw_i  (irq_softw_i),
        .irq_timer_i  (irq_timer_i),
        .state_i      (state_if.reader),
        .raw_irq_o    (raw_irq),
        .irq_pending_o(irq_pending),
        .irq_cause_o  (irq_cause)
    );

    trap_ctrl trap_ctrl_i (
        .ex_valid_i       (ex_valid_i),
        .excp_ferr_i      (excp_ferr_i),
        .excp_uerr_i      (excp_uerr_i),
        .excp_maif_i      (excp_maif_i),
        .excp_mala_i      (excp_mala_i),
        .excp_masa_i      (excp_masa_i),
        .excp_ilgl_i      (excp_ilgl_i),
        .excp_ecall_i     (excp_ecall_i),
        .excp_pc_i        (excp_pc_i),
        .excp_ins_i       (excp_ins_i),
        .trap_rtn_i       (trap_rtn_i),
        .irq_pending_i    (irq_pending),
        .irq_cause_i      (irq_cause),
        .state_i          (state_if.reader),
        .jump_to_trap_o   (jump_to_trap_o),
        .trap_cause_o     (trap_cause_o),
        .trap_entry_addr_o(trap_entry_addr_o),
        .trap_rtn_addr_o  (trap_rtn_addr_o),
        .upd_o            (upd_if.source)
    );

    csr_access csr_access_i (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .exs_en_i      (exs_en_i),
        .access_i      (access_i),
        .addr_i        (addr_i),
        .raw_irq_i     (raw_irq),
        .state_i       (state_if.reader),
        .rd_data_o     (rd_data_o),
        .bad_csr_addr_o(bad_csr_addr_o),
        .readonly_csr_o(readonly_csr_o),
        .priv_too_low_o(priv_too_low_o)
    );

    csr_regfile csr_regfile_i (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .exs_en_i (exs_en_i),
        .wr_i     (wr_i),
        .wr_addr_i(wr_addr_i),
        .wr_data_i(wr_data_i),
        .upd_i    (upd_if.sink),
        .state_o  (state_if.owner)
    );

endmodule

`default_nettype wire

//--- bench/tb_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module tb_csr;

    localparam logic [2:0] OP_READ  = 3'd0;
    localparam logic [2:0] OP_WRITE = 3'd1;
    localparam logic [2:0] OP_EXCP  = 3'd2;
    localparam logic [2:0] OP_IRQ   = 3'd3;
    localparam logic [2:0] OP_MRET  = 3'd4;
    localparam logic [1:0] MODE_U   = 2'd0;
    localparam logic [1:0] MODE_M   = 2'd3;

    // check mask bits 0 rd_data, 1 bad, 2 readonly, 3 priv, 4 mode,
    // 5 cause, 6 entry, 7 return, 8 interrupt, 9 jump
    // flag bits 0 bad, 1 readonly, 2 priv, 3 interrupt, 4 jump
    typedef struct packed {
        logic [2:0]  op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] ins;
        logic [6:0]  excp;
        logic [2:0]  irq;
        logic [31:0] exp_val;
        logic [31:0] exp_addr;
        logic [1:0]  exp_mode;
        logic [4:0]  exp_flags;
        logic [9:0]  mask;
    } row_t;

    logic        clk_i, resetb_i, exs_en_i, access_i, wr_i, ex_valid_i;
    logic [11:0] addr_i, wr_addr_i;
    logic [31:0] wr_data_i, excp_pc_i, excp_ins_i;
    logic        irq_extern_i, irq_softw_i, irq_timer_i, trap_rtn_i;
    logic        excp_ferr_i, excp_uerr_i, excp_maif_i, excp_mala_i;
    logic        excp_masa_i, excp_ilgl_i, excp_ecall_i;
    logic        bad_csr_addr_o, readonly_csr_o, priv_too_low_o;
    logic        interrupt_o, jump_to_trap_o;
    logic [31:0] rd_data_o, trap_entry_addr_o, trap_rtn_addr_o, trap_cause_o;
    logic [1:0]  mode_o;

    row_t        rows[$];
    integer      seed;
    logic [31:0] scratch_val;

    csr_top csr_top_i (
        .clk_i(clk_i), .resetb_i(resetb_i), .exs_en_i(exs_en_i),
        .access_i(access_i), .addr_i(addr_i), .bad_csr_addr_o(bad_csr_addr_o),
        .readonly_csr_o(readonly_csr_o), .priv_too_low_o(priv_too_low_o),
        .rd_data_o(rd_data_o), .wr_i(wr_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
        .ex_valid_i(ex_valid_i), .irq_extern_i(irq_extern_i), .irq_softw_i(irq_softw_i),
        .irq_timer_i(irq_timer_i), .excp_ferr_i(excp_ferr_i), .excp_uerr_i(excp_uerr_i),
        .excp_maif_i(excp_maif_i), .excp_mala_i(excp_mala_i), .excp_masa_i(excp_masa_i),
        .excp_ilgl_i(excp_ilgl_i), .excp_ecall_i(excp_ecall_i), .excp_pc_i(excp_pc_i),
        .excp_ins_i(excp_ins_i), .trap_rtn_i(trap_rtn_i), .interrupt_o(interrupt_o),
        .jump_to_trap_o(jump_to_trap_o), .trap_entry_addr_o(trap_entry_addr_o),
        .trap_rtn_addr_o(trap_rtn_addr_o), .mode_o(mode_o), .trap_cause_o(trap_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        access_i   = 1'b0;
        wr_i       = 1'b0;
        ex_valid_i = 1'b0;
        trap_rtn_i = 1'b0;
        addr_i     = '0;
        wr_addr_i  = '0;
        wr_data_i  = '0;
        excp_pc_i  = '0;
        excp_ins_i = '0;
        {excp_ferr_i, excp_uerr_i, excp_maif_i, excp_mala_i} = 4'b0;
        {excp_masa_i, excp_ilgl_i, excp_ecall_i} = 3'b0;
        {irq_extern_i, irq_softw_i, irq_timer_i} = 3'b0;
    endtask

    // after reset no trap or interrupt may be signalled
    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while ((interrupt_o !== 1'b0 || jump_to_trap_o !== 1'b0) && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (interrupt_o !== 1'b0 || jump_to_trap_o !== 1'b0) begin
            $display("Timeout: trap outputs did not go idle after reset");
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // table rows
    // --------------------------------------------------
    task automatic add_read(input logic [11:0] addr, input logic [31:0] exp_data,
                            input logic [2:0] flags, input logic [1:0] mode);
        row_t r;
        r = '0;
        r.op        = OP_READ;
        r.addr      = addr;
        r.exp_val   = exp_data;
        r.exp_mode  = mode;
        r.exp_flags = {2'b00, flags};
        r.mask      = 10'h31f;
        rows.push_back(r);
    endtask

    task automatic add_write(input logic [11:0] addr, input logic [31:0] data);
        row_t r;
        r = '0;
        r.op   = OP_WRITE;
        r.addr = addr;
        r.data = data;
        r.mask = 10'h200;
        rows.push_back(r);
    endtask

    task automatic add_excp(input logic [6:0] excp, input logic [31:0] pc,
                            input logic [31:0] ins, input logic [31:0] cause,
                            input logic [31:0] entry, input logic [1:0] mode);
        row_t r;
        r = '0;
        r.op        = OP_EXCP;
        r.excp      = excp;
        r.data      = pc;
        r.ins       = ins;
        r.exp_val   = cause;
        r.exp_addr  = entry;
        r.exp_mode  = mode;
        r.exp_flags = 5'b10000;
        r.mask      = 10'h370;
        rows.push_back(r);
    endtask

    task automatic add_irq(input logic [2:0] lines, input logic exp_irq,
                           input logic [31:0] cause, input logic [31:0] entry);
        row_t r;
        r = '0;
        r.op        = OP_IRQ;
        r.irq       = lines;
        r.exp_val   = cause;
        r.exp_addr  = entry;
        r.exp_flags = {1'b0, exp_irq, 3'b000};
        r.mask      = exp_irq ? 10'h360 : 10'h300;
        rows.push_back(r);
    endtask

    task automatic add_mret(input logic [31:0] rtn, input logic [1:0] mode);
        row_t r;
        r = '0;
        r.op       = OP_MRET;
        r.exp_addr = rtn;
        r.exp_mode = mode;
        r.mask     = 10'h290;
        rows.push_back(r);
    endtask

    task automatic build_table();
        scratch_val = $random(seed);
        // reset values and id registers
        add_read(`CSR_A_MSTATUS, 32'h0, 3'b000, MODE_M);
        add_read(`CSR_A_MTVEC, `CSR_RESET_VECTOR, 3'b000, MODE_M);
        add_read(`CSR_A_VENDOR, `CSR_VENDOR_ID, 3'b010, MODE_M);
        add_read(`CSR_A_ARCH, `CSR_ARCH_ID, 3'b010, MODE_M);
        add_read(`CSR_A_IMPL, `CSR_IMPL_ID, 3'b010, MODE_M);
        add_read(`CSR_A_HART, `CSR_HART_ID, 3'b010, MODE_M);
        // masked writes
        add_write(`CSR_A_MSTATUS, 32'hffff_ffff);
        add_read(`CSR_A_MSTATUS, 32'h0000_1888, 3'b000, MODE_M);
        add_write(`CSR_A_MSTATUS, 32'h0);
        add_write(`CSR_A_MIE, 32'hffff_ffff);
        add_read(`CSR_A_MIE, 32'h0000_0888, 3'b000, MODE_M);
        add_write(`CSR_A_MIP, 32'hffff_ffff);
        add_read(`CSR_A_MIP, 32'h0000_0888, 3'b000, MODE_M);
        add_write(`CSR_A_MIP, 32'h0);
        add_write(`CSR_A_MTVEC, 32'h0000_0203);
        add_read(`CSR_A_MTVEC, 32'h0000_0201, 3'b000, MODE_M);
        add_write(`CSR_A_MSCRATCH, scratch_val);
        add_read(`CSR_A_MSCRATCH, scratch_val, 3'b000, MODE_M);
        add_read(12'h7c0, 32'h0, 3'b001, MODE_M);
        add_read(`CSR_A_MISA, 32'h0, 3'b000, MODE_M);
        // illegal instruction trap from machine mode
        add_write(`CSR_A_MTVEC, 32'h0000_0400);
        add_excp(7'b000_0010, 32'h0000_1234, 32'hdead_beef, 32'd2, 32'h0000_0400, MODE_M);
        add_read(`CSR_A_MEPC, 32'h0000_1234, 3'b000, MODE_M);
        add_read(`CSR_A_MTVAL, 32'hdead_beef, 3'b000, MODE_M);
        add_read(`CSR_A_MCAUSE, 32'd2, 3'b000, MODE_M);
        add_read(`CSR_A_MSTATUS, 32'h0000_1800, 3'b000, MODE_M);
        // mret into user mode and then ecall
        add_write(`CSR_A_MSTATUS, 32'h0000_0080);
        add_write(`CSR_A_MEPC, 32'h0000_2000);
        add_mret(32'h0000_2000, MODE_U);
        add_read(`CSR_A_MSCRATCH, scratch_val, 3'b100, MODE_U);
        add_excp(7'b000_0001, 32'h0000_3000, 32'h0000_0073, 32'd8, 32'h0000_0400, MODE_M);
        // interrupt priority and vectoring
        add_write(`CSR_A_MSTATUS, 32'h0000_0008);
        add_irq(3'b111, 1'b1, 32'h8000_000b, 32'h0000_0400);
        add_write(`CSR_A_MTVEC, 32'h0000_0401);
        add_irq(3'b111, 1'b1, 32'h8000_000b, 32'h0000_042c);
        add_irq(3'b011, 1'b1, 32'h8000_0003, 32'h0000_040c);
        add_write(`CSR_A_MSTATUS, 32'h0);
        add_irq(3'b111, 1'b0, 32'h0, 32'h0);
    endtask

    // --------------------------------------------------
    // apply one row and check comb outputs before the state
    // --------------------------------------------------
    task automatic apply_row(input row_t r);
        @(negedge clk_i);
        access_i   = (r.op == OP_READ);
        addr_i     = r.addr;
        wr_i       = (r.op == OP_WRITE);
        wr_addr_i  = r.addr;
        wr_data_i  = r.data;
        ex_valid_i = (r.op == OP_EXCP);
        {excp_ferr_i, excp_uerr_i, excp_maif_i, excp_mala_i} = r.excp[6:3];
        {excp_masa_i, excp_ilgl_i, excp_ecall_i} = r.excp[2:0];
        excp_pc_i  = r.data;
        excp_ins_i = r.ins;
        {irq_extern_i, irq_softw_i, irq_timer_i} = r.irq;
        trap_rtn_i = (r.op == OP_MRET);
        #1;
        if (r.mask[5]) check_value("trap_cause_o", trap_cause_o, r.exp_val);
        if (r.mask[6]) check_value("trap_entry_addr_o", trap_entry_addr_o, r.exp_addr);
        if (r.mask[7]) check_value("trap_rtn_addr_o", trap_rtn_addr_o, r.exp_addr);
        if (r.mask[8]) check_value("interrupt_o", 32'(interrupt_o), 32'(r.exp_flags[3]));
        if (r.mask[9]) check_value("jump_to_trap_o", 32'(jump_to_trap_o), 32'(r.exp_flags[4]));
        @(negedge clk_i);
        drive_idle();
        if (r.mask[0]) check_value("rd_data_o", rd_data_o, r.exp_val);
        if (r.mask[1]) check_value("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'(r.exp_flags[0]));
        if (r.mask[2]) check_value("readonly_csr_o", 32'(readonly_csr_o), 32'(r.exp_flags[1]));
        if (r.mask[3]) check_value("priv_too_low_o", 32'(priv_too_low_o), 32'(r.exp_flags[2]));
        if (r.mask[4]) check_value("mode_o", 32'(mode_o), 32'(r.exp_mode));
    endtask

    initial begin
        seed     = 32'h8888_9543;
        resetb_i = 1'b0;
        exs_en_i = 1'b1;
        drive_idle();
        build_table();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        resetb_i = 1'b1;
        wait_idle(20);
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/csr_pkg.sv
common/csr_if.sv
hdl/irq_unit.sv
trap/trap_ctrl.sv
hdl/csr_access.sv
regfile/csr_regfile.sv
hdl/csr_top.sv
bench/tb_csr.sv

//--- run.sh
#!/bin/sh
# build and run the csr testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_csr \
    -f src.f -Mdir obj_dir -o sim_tb_csr
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_csr 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
